//--- Makefile
# Verilator build and run for the HDMI video testbench

VERILATOR ?= verilator
TOP       ?= hdmi_video_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# The log decides pass or fail, so a crash without the pass line also fails
run: compile
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	grep -q "^TB PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- sim/hdmi_video_assert.sv
// Concurrent checks on the embedded sync decoder outputs and their bind into the decoder
`timescale 1ns/1ps
`default_nettype none

module hdmi_video_assert (
  input logic                        hdmi_rx_clk,
  input logic                        reset_i,
  input logic                        pix_valid_i,
  input logic                        pix_sol_i,
  input logic                        pix_sof_i,
  input logic                        line_len_valid_i,
  input logic [video_pkg::VID_W-1:0] pix_data_i
);

  // A frame starts on the first pixel of a line, right after the withheld SAV code
  sof_on_line_start_a : assert property (@(posedge hdmi_rx_clk) disable iff (reset_i)
    pix_sof_i |-> (pix_valid_i && pix_sol_i && !$past(pix_valid_i)))
    else $error("start of frame strobe without a valid start-of-line pixel");

  // The length report follows the last pixel of its line and never meets a pixel
  len_apart_from_pix_a : assert property (@(posedge hdmi_rx_clk) disable iff (reset_i)
    line_len_valid_i |-> (!pix_valid_i && $past(pix_valid_i)))
    else $error("line length strobe not right after the last pixel of its line");

  // The first preamble word must be withheld once its code is recognised
  no_preamble_pix_a : assert property (@(posedge hdmi_rx_clk) disable iff (reset_i)
    pix_valid_i |-> (pix_data_i != video_pkg::SYNC_FF))
    else $error("preamble word forwarded as a pixel");

endmodule

bind hdmi_rx_sync hdmi_video_assert hdmi_video_assert_i (
  .hdmi_rx_clk      (hdmi_rx_clk),
  .reset_i          (reset_i),
  .pix_valid_i      (pix_valid_o),
  .pix_sol_i        (pix_sol_o),
  .pix_sof_i        (pix_sof_o),
  .line_len_valid_i (line_len_valid_o),
  .pix_data_i       (pix_data_o)
);

`default_nettype wire

//--- sim/hdmi_video_tb.sv
// Directed testbench for the video top level with loopback, injected sync streams and timeout
`timescale 1ns/1ps
`default_nettype none

module hdmi_video_tb;

  // Small raster so that a whole frame takes a few hundred cycles
  localparam int H_ACTIVE = 32;
  localparam int H_BLANK = 8;
  localparam int V_ACTIVE = 3;
  localparam int V_BLANK = 2;
  localparam int LINE_CYC = H_ACTIVE + H_BLANK + 8;
  localparam int FRAME_CYC = LINE_CYC * (V_ACTIVE + V_BLANK);
  // Injected lines use their own blanking width
  localparam int INJ_BLANK = 6;
  localparam int INJ_LINE_MAX = 16 + INJ_BLANK + H_ACTIVE;
  localparam int LOOP_FRAMES = 10;
  localparam int INJ_LINES = 14;
  localparam int TEST_CYCLES = 19 + LOOP_FRAMES * FRAME_CYC + INJ_LINES * INJ_LINE_MAX;
  localparam int TIMEOUT_CYC = 3 * TEST_CYCLES;

  logic hdmi_rx_clk;
  logic reset_i;
  logic [video_pkg::VID_W-1:0] rx_data;
  logic [1:0] mode_req;
  logic [23:0] solid_req;
  logic [video_pkg::VID_W-1:0] hdmi_tx_data_o;
  logic pix_valid_o;
  logic [video_pkg::VID_W-1:0] pix_data_o;
  logic pix_sol_o;
  logic pix_sof_o;
  logic [video_pkg::CNT_W-1:0] line_len_o;
  logic line_len_valid_o;
  logic sync_err_o;

  // Loopback or injected words feed the receiver
  logic loop_en;
  logic chk_en;
  logic [video_pkg::VID_W-1:0] loop_word;
  logic [video_pkg::VID_W-1:0] inj_word;
  logic [video_pkg::VID_W-1:0] pix_q [$];
  int len_q [$];

  // Scoreboard state
  int errors;
  int checks;
  int n_pix;
  int n_sol;
  int n_sof;
  int n_len;
  int n_err;
  int s_pix;
  int s_sol;
  int s_sof;
  int s_len;
  int s_err;
  int pix_idx;
  int sol_frame;
  int pix_frame;
  int frame_cyc;
  logic frame_open;
  logic [1:0] frame_mode;
  logic [23:0] frame_solid;
  int timeout_cnt;
  int seed_val;

  assign rx_data = loop_en ? loop_word : inj_word;

  hdmi_video_top #(
    .H_ACTIVE (H_ACTIVE),
    .H_BLANK  (H_BLANK),
    .V_ACTIVE (V_ACTIVE),
    .V_BLANK  (V_BLANK)
  ) hdmi_video_top_i (
    .hdmi_rx_clk      (hdmi_rx_clk),
    .reset_i          (reset_i),
    .hdmi_rx_data_i   (rx_data),
    .pattern_mode_i   (mode_req),
    .solid_ycbcr_i    (solid_req),
    .hdmi_tx_data_o   (hdmi_tx_data_o),
    .pix_valid_o      (pix_valid_o),
    .pix_data_o       (pix_data_o),
    .pix_sol_o        (pix_sol_o),
    .pix_sof_o        (pix_sof_o),
    .line_len_o       (line_len_o),
    .line_len_valid_o (line_len_valid_o),
    .sync_err_o       (sync_err_o)
  );

  initial begin
    hdmi_rx_clk = 1'b0;
    forever #5 hdmi_rx_clk = ~hdmi_rx_clk;
  end

  // The transmit word is picked up half a cycle after it leaves the DUT
  always @(negedge hdmi_rx_clk) begin
    loop_word <= hdmi_tx_data_o;
  end

  // ********************
  // Checking helpers
  // ********************

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] t=%0t %s: got %h, expected %h", $time, name, got, exp);
    end
  endtask

  // Expected pattern word for a pixel index, straight from the pattern rules
  function automatic logic [15:0] ref_pixel(input logic [1:0] mode, input logic [23:0] solid,
                                            input int idx);
    int bar;
    logic [2:0] sel;
    logic [7:0] y;
    logic [7:0] cb;
    logic [7:0] cr;
    bar = idx / (H_ACTIVE / 8);
    if (bar > 7) begin
      bar = 7;
    end
    sel = 3'(bar);
    if (mode == video_pkg::MODE_RAMP) begin
      y = 8'(idx);
      cb = 8'd128;
      cr = 8'd128;
    end else if (mode == video_pkg::MODE_SOLID) begin
      y = solid[23:16];
      cb = solid[15:8];
      cr = solid[7:0];
    end else begin
      y = video_pkg::BAR_Y[sel];
      cb = video_pkg::BAR_CB[sel];
      cr = video_pkg::BAR_CR[sel];
    end
    return {y, (idx % 2 == 1) ? cr : cb};
  endfunction

  // Pixel words never hold a 00 or FF byte so they cannot look like a preamble
  function automatic logic [15:0] rand_pixel();
    logic [7:0] hi;
    logic [7:0] lo;
    hi = 8'(1 + $urandom % 254);
    lo = 8'(1 + $urandom % 254);
    return {hi, lo};
  endfunction

  function automatic int rand_len();
    return 4 + int'($urandom % (H_ACTIVE - 3));
  endfunction

  // ********************
  // Output monitor
  // ********************

  always @(negedge hdmi_rx_clk) begin
    if (!reset_i && chk_en) begin
      frame_cyc++;
      if (pix_sof_o) begin
        check_val("pix_valid_o and pix_sol_o at pix_sof_o", 32'(pix_valid_o & pix_sol_o), 32'd1);
      end
      if (pix_valid_o) begin
        if (pix_sol_o) begin
          pix_idx = 0;
        end else begin
          pix_idx++;
        end
        // In loopback a frame is closed by the next start of frame
        if (pix_sof_o) begin
          if (loop_en && frame_open) begin
            check_val("pix_sol_o per frame", 32'(sol_frame), 32'(V_ACTIVE));
            check_val("pix_valid_o per frame", 32'(pix_frame), 32'(V_ACTIVE * H_ACTIVE));
            check_val("pix_sof_o period", 32'(frame_cyc), 32'(FRAME_CYC));
          end
          frame_open = 1'b1;
          sol_frame = 0;
          pix_frame = 0;
          frame_cyc = 0;
          frame_mode = mode_req;
          frame_solid = solid_req;
        end
        if (pix_sol_o) begin
          sol_frame++;
        end
        pix_frame++;
        if (loop_en) begin
          check_val("pix_data_o", 32'(pix_data_o), 32'(ref_pixel(frame_mode, frame_solid, pix_idx)));
        end else if (pix_q.size() == 0) begin
          errors++;
          $display("Pixel strobe at %0t without any injected pixel left to match it", $time);
        end else begin
          check_val("pix_data_o", 32'(pix_data_o), 32'(pix_q.pop_front()));
        end
        n_pix++;
      end
      if (line_len_valid_o) begin
        check_val("pix_valid_o at line_len_valid_o", 32'(pix_valid_o), 32'd0);
        if (loop_en) begin
          check_val("line_len_o", 32'(line_len_o), 32'(H_ACTIVE));
        end else if (len_q.size() == 0) begin
          errors++;
          $display("Line length strobe at %0t for a line that should not report one", $time);
        end else begin
          check_val("line_len_o", 32'(line_len_o), 32'(len_q.pop_front()));
        end
        n_len++;
      end
      if (sync_err_o) begin
        n_err++;
      end
      // Counters that tests wait on are updated last
      if (pix_valid_o && pix_sol_o) begin
        n_sol++;
      end
      if (pix_valid_o && pix_sof_o) begin
        n_sof++;
      end
    end
  end

  always @(negedge hdmi_rx_clk) begin
    timeout_cnt++;
    if (timeout_cnt >= TIMEOUT_CYC) begin
      $display("Run stopped after %0d cycles while waiting for the DUT", timeout_cnt);
      $display("TB FAILED");
      $finish;
    end
  end

  // ********************
  // Stimulus helpers
  // ********************

  task automatic wait_sof();
    int snap;
    snap = n_sof;
    wait (n_sof != snap);
  endtask

  task automatic wait_sol();
    int snap;
    snap = n_sol;
    wait (n_sol != snap);
  endtask

  task automatic take_snap();
    s_pix = n_pix;
    s_sol = n_sol;
    s_sof = n_sof;
    s_len = n_len;
    s_err = n_err;
  endtask

  task automatic check_counts(input int pix, input int sol, input int sof, input int len,
                              input int err);
    check_val("pix_valid_o count", 32'(n_pix - s_pix), 32'(pix));
    check_val("pix_sol_o count", 32'(n_sol - s_sol), 32'(sol));
    check_val("pix_sof_o count", 32'(n_sof - s_sof), 32'(sof));
    check_val("line_len_valid_o count", 32'(n_len - s_len), 32'(len));
    check_val("sync_err_o count", 32'(n_err - s_err), 32'(err));
  endtask

  task automatic send_word(input logic [15:0] w);
    @(negedge hdmi_rx_clk);
    inj_word = w;
  endtask

  // XY byte is 1, F, V, H and the protection bits, with F fixed at 0
  task automatic send_code(input logic v, input logic h, input logic bad);
    logic [7:0] xy;
    xy = {1'b1, 1'b0, v, h, v ^ h, h, v, v ^ h};
    if (bad) begin
      xy[0] = ~xy[0];
    end
    send_word(video_pkg::SYNC_FF);
    send_word(video_pkg::SYNC_00);
    send_word(video_pkg::SYNC_00);
    send_word({xy, xy});
  endtask

  // EAV, blanking, SAV and n words; only a good V=0 line yields pixels and a length
  task automatic send_line(input logic v, input int n, input logic bad_sav);
    logic [15:0] w;
    send_code(v, 1'b1, 1'b0);
    repeat (INJ_BLANK) send_word(video_pkg::BLANK_WORD);
    send_code(v, 1'b0, bad_sav);
    for (int i = 0; i < n; i++) begin
      w = rand_pixel();
      if (!v && !bad_sav) begin
        pix_q.push_back(w);
      end
      send_word(w);
    end
    if (!v && !bad_sav) begin
      len_q.push_back(n);
    end
  endtask

  task automatic check_strobes_low();
    check_val("pix_valid_o", 32'(pix_valid_o), 32'd0);
    check_val("pix_sol_o", 32'(pix_sol_o), 32'd0);
    check_val("pix_sof_o", 32'(pix_sof_o), 32'd0);
    check_val("line_len_valid_o", 32'(line_len_valid_o), 32'd0);
    check_val("sync_err_o", 32'(sync_err_o), 32'd0);
  endtask

  // ********************
  // Directed tests
  // ********************

  // Outputs stay idle in reset and the first EAV word leaves on the third edge after it
  task automatic reset_test();
    reset_i = 1'b1;
    repeat (16) begin
      @(negedge hdmi_rx_clk);
      check_strobes_low();
      check_val("hdmi_tx_data_o", 32'(hdmi_tx_data_o), 32'(video_pkg::BLANK_WORD));
    end
    reset_i = 1'b0;
    for (int k = 1; k <= 3; k++) begin
      @(negedge hdmi_rx_clk);
      check_strobes_low();
      if (k == 3) begin
        check_val("hdmi_tx_data_o", 32'(hdmi_tx_data_o), 32'(video_pkg::SYNC_FF));
      end else begin
        check_val("hdmi_tx_data_o", 32'(hdmi_tx_data_o), 32'(video_pkg::BLANK_WORD));
      end
    end
  endtask

  // Two whole bar frames in loopback, with every line reporting H_ACTIVE
  task automatic bars_test();
    wait_sof();
    take_snap();
    wait_sof();
    wait_sof();
    check_counts(2 * V_ACTIVE * H_ACTIVE, 2 * V_ACTIVE, 2, 2 * V_ACTIVE, 0);
  endtask

  // A request in the second active line must only take effect on the next frame
  task automatic mode_change_test(input logic [1:0] mode, input logic [23:0] solid);
    wait_sof();
    wait_sol();
    @(negedge hdmi_rx_clk);
    mode_req = mode;
    solid_req = solid;
    take_snap();
    wait_sof();
    wait_sof();
    check_val("sync_err_o count", 32'(n_err - s_err), 32'd0);
  endtask

  // Hands the receiver over to injected words behind a line that is not checked
  task automatic inject_start();
    chk_en = 1'b0;
    @(negedge hdmi_rx_clk);
    loop_en = 1'b0;
    frame_open = 1'b0;
    send_line(1'b1, 8, 1'b0);
    pix_q.delete();
    len_q.delete();
    @(negedge hdmi_rx_clk);
    chk_en = 1'b1;
  endtask

  task automatic len_inject_test();
    int total;
    int n;
    total = 0;
    take_snap();
    send_line(1'b1, 8, 1'b0);
    repeat (3) begin
      n = rand_len();
      total += n;
      send_line(1'b0, n, 1'b0);
    end
    // A closing EAV is needed to report the last line
    send_line(1'b1, 8, 1'b0);
    repeat (8) send_word(video_pkg::BLANK_WORD);
    check_counts(total, 3, 1, 3, 0);
  endtask

  // The corrupted SAV is ignored, so its line stays inactive and V is kept
  task automatic protection_test();
    int n1;
    int n3;
    n1 = rand_len();
    n3 = rand_len();
    take_snap();
    send_line(1'b0, n1, 1'b0);
    send_line(1'b0, rand_len(), 1'b1);
    send_line(1'b0, n3, 1'b0);
    send_line(1'b1, 8, 1'b0);
    repeat (8) send_word(video_pkg::BLANK_WORD);
    check_counts(n1 + n3, 2, 1, 2, 1);
  endtask

  task automatic blanking_test();
    take_snap();
    repeat (3) send_line(1'b1, rand_len(), 1'b0);
    repeat (8) send_word(video_pkg::BLANK_WORD);
    check_counts(0, 0, 0, 0, 0);
  endtask

  initial begin
    seed_val = $urandom(32'h4894);
    reset_i = 1'b1;
    mode_req = video_pkg::MODE_BARS;
    solid_req = 24'h108080;
    inj_word = video_pkg::BLANK_WORD;
    loop_word = video_pkg::BLANK_WORD;
    loop_en = 1'b1;
    chk_en = 1'b0;
    errors = 0;
    checks = 0;
    n_pix = 0;
    n_sol = 0;
    n_sof = 0;
    n_len = 0;
    n_err = 0;
    pix_idx = 0;
    sol_frame = 0;
    pix_frame = 0;
    frame_cyc = 0;
    frame_open = 1'b0;
    frame_mode = video_pkg::MODE_BARS;
    frame_solid = '0;
    timeout_cnt = 0;

    reset_test();
    chk_en = 1'b1;
    bars_test();
    mode_change_test(video_pkg::MODE_RAMP, 24'h108080);
    mode_change_test(video_pkg::MODE_SOLID, {8'(16 + $urandom % 220), 8'(16 + $urandom % 220),
                                             8'(16 + $urandom % 220)});
    inject_start();
    len_inject_test();
    protection_test();
    blanking_test();

    repeat (8) @(negedge hdmi_rx_clk);
    check_val("injected pixels left", 32'(pix_q.size()), 32'd0);
    check_val("injected lengths left", 32'(len_q.size()), 32'd0);
    $display("Checks %0d, errors %0d, pixels %0d, lines %0d, frames %0d, sync errors %0d",
             checks, errors, n_pix, n_len, n_sof, n_err);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
verilog/video_pkg.sv
verilog/video_delay.sv
verilog/hdmi_rx_sync.sv
verilog/video_pattern.sv
verilog/hdmi_tx_raster.sv
verilog/hdmi_video_top.sv
sim/hdmi_video_assert.sv
sim/hdmi_video_tb.sv

//--- verilog/hdmi_rx_sync.sv
// Embedded sync decoder with pixel strobes, line length measurement and XY error flag
`timescale 1ns/1ps
`default_nettype none

module hdmi_rx_sync (
  input  logic                        hdmi_rx_clk,
  input  logic                        reset_i,
  input  logic [video_pkg::VID_W-1:0] rx_data_i,
  output logic                        pix_valid_o,
  output logic                        pix_sol_o,
  output logic                        pix_sof_o,
  output logic                        sync_err_o,
  output logic                        line_len_valid_o,
  output logic [video_pkg::VID_W-1:0] pix_data_o,
  output logic [video_pkg::CNT_W-1:0] line_len_o
);

  logic [video_pkg::VID_W-1:0] head_data;
  // Match flags and pixel tags of the words held in the delay line
  // Bit 0 belongs to the newest held word and bit 2 to the delay head
  logic [2:0] ff_sr;
  logic [1:0] zz_sr;
  logic [2:0] tag_sr;
  logic [7:0] xy_lo;
  logic hit;
  logic xy_ok;
  logic good_xy;
  logic bad_xy;
  logic head_pix;
  logic first_pix;
  logic act_q;
  logic v_q;
  logic sof_pend_q;
  logic [video_pkg::CNT_W-1:0] pix_cnt_q;

  // Three words of look-behind so the preamble can be withheld once the XY word shows up
  video_delay #(
    .T     (logic [video_pkg::VID_W-1:0]),
    .DEPTH (3)
  ) video_delay_i (
    .hdmi_rx_clk (hdmi_rx_clk),
    .reset_i     (reset_i),
    .din_i       (rx_data_i),
    .dout_o      (head_data)
  );

  // ********************
  // Sync code detection
  // ********************

  // The current input is an XY word when the three held words were FF, 00, 00
  assign hit = ff_sr[2] & zz_sr[1] & zz_sr[0];
  assign xy_lo = rx_data_i[7:0];
  // Both halves must agree and the protection bits must match F, V and H
  assign xy_ok = (rx_data_i[15:8] == xy_lo) &&
                 (xy_lo == video_pkg::xy_code(xy_lo[6], xy_lo[5], xy_lo[4]));
  assign good_xy = hit & xy_ok;
  assign bad_xy = hit & ~xy_ok;

  // The head word is a pixel if it was tagged on entry and is not the FF of a code
  assign head_pix = tag_sr[2] & ~hit;
  assign first_pix = head_pix && (pix_cnt_q == '0);

  always_ff @(posedge hdmi_rx_clk) begin
    if (reset_i) begin
      ff_sr <= '0;
      zz_sr <= '0;
      tag_sr <= '0;
    end else begin
      ff_sr <= {ff_sr[1:0], rx_data_i == video_pkg::SYNC_FF};
      zz_sr <= {zz_sr[0], rx_data_i == video_pkg::SYNC_00};
      // A detected code takes back the tags of the preamble words already held
      tag_sr <= {tag_sr[1] & ~hit, tag_sr[0] & ~hit, act_q & ~hit};
    end
  end

  // ********************
  // Line and frame state
  // ********************

  // A bad XY word leaves V and the active state untouched
  always_ff @(posedge hdmi_rx_clk) begin
    if (reset_i) begin
      act_q <= 1'b0;
      v_q <= 1'b0;
      sof_pend_q <= 1'b0;
    end else begin
      if (first_pix) begin
        sof_pend_q <= 1'b0;
      end
      if (good_xy) begin
        v_q <= xy_lo[5];
        // Only an SAV on a V=0 line opens the active region
        act_q <= ~xy_lo[4] & ~xy_lo[5];
        // The first V=0 code after a V=1 line arms the start-of-frame strobe
        if (~xy_lo[5] & v_q) begin
          sof_pend_q <= 1'b1;
        end
      end
    end
  end

  // Counts pixels leaving the delay head since the last SAV
  always_ff @(posedge hdmi_rx_clk) begin
    if (reset_i) begin
      pix_cnt_q <= '0;
    end else if (good_xy && !xy_lo[4]) begin
      pix_cnt_q <= '0;
    end else if (head_pix) begin
      pix_cnt_q <= pix_cnt_q + 1'b1;
    end
  end

  // ********************
  // Output registers
  // ********************

  always_ff @(posedge hdmi_rx_clk) begin
    if (reset_i) begin
      pix_valid_o <= 1'b0;
      pix_sol_o <= 1'b0;
      pix_sof_o <= 1'b0;
      line_len_valid_o <= 1'b0;
      sync_err_o <= 1'b0;
    end else begin
      pix_valid_o <= head_pix;
      pix_sol_o <= first_pix;
      pix_sof_o <= first_pix & sof_pend_q;
      // The last pixel of the line was counted one cycle before its EAV XY word
      line_len_valid_o <= good_xy & xy_lo[4] & act_q;
      sync_err_o <= bad_xy;
    end
  end

  // Data only changes on real pixels so codes never reach pix_data_o
  always_ff @(posedge hdmi_rx_clk) begin
    if (head_pix) begin
      pix_data_o <= head_data;
    end
    if (good_xy && xy_lo[4]) begin
      line_len_o <= pix_cnt_q;
    end
  end

endmodule

`default_nettype wire

//--- verilog/hdmi_tx_raster.sv
// Transmit raster counters, sync code insertion and blanking around the test pattern
`timescale 1ns/1ps
`default_nettype none

module hdmi_tx_raster #(
  parameter int H_ACTIVE = 64,
  parameter int H_BLANK  = 16,
  parameter int V_ACTIVE = 4,
  parameter int V_BLANK  = 2
) (
  input  logic                        hdmi_rx_clk,
  input  logic                        reset_i,
  input  logic [1:0]                  mode_i,
  input  logic [23:0]                 solid_ycbcr_i,
  output logic [video_pkg::VID_W-1:0] tx_data_o
);

  typedef logic [video_pkg::CNT_W-1:0] cnt_t;

  // A line is EAV, horizontal blanking, SAV and then the active pixels
  localparam int LINE_LEN = H_ACTIVE + H_BLANK + 8;
  localparam int FRAME_LINES = V_BLANK + V_ACTIVE;
  localparam cnt_t LAST_H = cnt_t'(LINE_LEN - 1);
  localparam cnt_t LAST_V = cnt_t'(FRAME_LINES - 1);
  localparam cnt_t SAV_START = cnt_t'(H_BLANK + 4);
  localparam cnt_t ACT_START = cnt_t'(H_BLANK + 8);
  localparam cnt_t FIRST_ACT_LINE = cnt_t'(V_BLANK);

  logic run_q;
  cnt_t h_cnt_q;
  cnt_t v_cnt_q;
  cnt_t sav_off;
  cnt_t pix_off;
  logic in_eav;
  logic in_sav;
  logic in_act;
  logic v_bit;
  video_pkg::tx_ctl_t ctl_raw;
  video_pkg::tx_ctl_t ctl;
  video_pkg::tx_ctl_t ctl_d;
  logic [video_pkg::VID_W-1:0] pat_word;

  // ********************
  // Raster counters
  // ********************

  // The counters start one cycle after reset so slot 0 is not sent twice
  always_ff @(posedge hdmi_rx_clk) begin
    if (reset_i) begin
      run_q <= 1'b0;
      h_cnt_q <= '0;
      v_cnt_q <= '0;
    end else begin
      run_q <= 1'b1;
      if (run_q) begin
        if (h_cnt_q == LAST_H) begin
          h_cnt_q <= '0;
          v_cnt_q <= (v_cnt_q == LAST_V) ? cnt_t'(0) : v_cnt_q + 1'b1;
        end else begin
          h_cnt_q <= h_cnt_q + 1'b1;
        end
      end
    end
  end

  assign in_eav = h_cnt_q < cnt_t'(4);
  assign in_sav = (h_cnt_q >= SAV_START) && (h_cnt_q < ACT_START);
  assign in_act = h_cnt_q >= ACT_START;
  // Vertical blanking comes first in the frame
  assign v_bit = v_cnt_q < FIRST_ACT_LINE;
  assign sav_off = h_cnt_q - SAV_START;
  assign pix_off = h_cnt_q - ACT_START;

  // One control word per slot, F is always 0 for progressive video
  always_comb begin
    ctl_raw.active = in_act;
    ctl_raw.code_en = in_eav | in_sav;
    ctl_raw.code_idx = in_eav ? h_cnt_q[1:0] : sav_off[1:0];
    ctl_raw.xy = video_pkg::xy_code(1'b0, v_bit, in_eav);
    ctl_raw.pix_idx = in_act ? pix_off : cnt_t'(0);
    ctl_raw.first_pix = in_act && (pix_off == '0) && (v_cnt_q == FIRST_ACT_LINE);
  end

  // Before the counters run the slot is plain blanking
  assign ctl = run_q ? ctl_raw : '0;

  // ********************
  // Pattern and alignment
  // ********************

  video_pattern #(
    .H_ACTIVE (H_ACTIVE)
  ) video_pattern_i (
    .hdmi_rx_clk   (hdmi_rx_clk),
    .reset_i       (reset_i),
    .mode_i        (mode_i),
    .solid_ycbcr_i (solid_ycbcr_i),
    .pix_idx_i     (ctl.pix_idx),
    .first_pix_i   (ctl.first_pix),
    .pat_data_o    (pat_word)
  );

  // Matches the one-cycle latency of the pattern generator
  video_delay #(
    .T     (video_pkg::tx_ctl_t),
    .DEPTH (1)
  ) video_delay_i (
    .hdmi_rx_clk (hdmi_rx_clk),
    .reset_i     (reset_i),
    .din_i       (ctl),
    .dout_o      (ctl_d)
  );

  // Code words first, then pattern on active V=0 slots, blanking everywhere else
  always_ff @(posedge hdmi_rx_clk) begin
    if (reset_i) begin
      tx_data_o <= video_pkg::BLANK_WORD;
    end else if (ctl_d.code_en) begin
      case (ctl_d.code_idx)
        2'd0: tx_data_o <= video_pkg::SYNC_FF;
        2'd3: tx_data_o <= {ctl_d.xy, ctl_d.xy};
        default: tx_data_o <= video_pkg::SYNC_00;
      endcase
    end else if (ctl_d.active && !ctl_d.xy[5]) begin
      tx_data_o <= pat_word;
    end else begin
      tx_data_o <= video_pkg::BLANK_WORD;
    end
  end

endmodule

`default_nettype wire

//--- verilog/hdmi_video_top.sv
// Video top level joining the embedded sync receiver and the pattern transmitter
`timescale 1ns/1ps
`default_nettype none

module hdmi_video_top #(
  parameter int H_ACTIVE = 64,
  parameter int H_BLANK  = 16,
  parameter int V_ACTIVE = 4,
  parameter int V_BLANK  = 2
) (
  input  logic                        hdmi_rx_clk,
  input  logic                        reset_i,
  input  logic [video_pkg::VID_W-1:0] hdmi_rx_data_i,
  input  logic [1:0]                  pattern_mode_i,
  input  logic [23:0]                 solid_ycbcr_i,
  output logic [video_pkg::VID_W-1:0] hdmi_tx_data_o,
  output logic                        pix_valid_o,
  output logic [video_pkg::VID_W-1:0] pix_data_o,
  output logic                        pix_sol_o,
  output logic                        pix_sof_o,
  output logic [video_pkg::CNT_W-1:0] line_len_o,
  output logic                        line_len_valid_o,
  output logic                        sync_err_o
);

  // ********************
  // Receive path
  // ********************

  // Pixels leave the decoder four cycles after their word arrives
  hdmi_rx_sync hdmi_rx_sync_i (
    .hdmi_rx_clk      (hdmi_rx_clk),
    .reset_i          (reset_i),
    .rx_data_i        (hdmi_rx_data_i),
    .pix_valid_o      (pix_valid_o),
    .pix_sol_o        (pix_sol_o),
    .pix_sof_o        (pix_sof_o),
    .sync_err_o       (sync_err_o),
    .line_len_valid_o (line_len_valid_o),
    .pix_data_o       (pix_data_o),
    .line_len_o       (line_len_o)
  );

  // ********************
  // Transmit path
  // ********************

  // Free-running raster on the same clock as the receiver
  hdmi_tx_raster #(
    .H_ACTIVE (H_ACTIVE),
    .H_BLANK  (H_BLANK),
    .V_ACTIVE (V_ACTIVE),
    .V_BLANK  (V_BLANK)
  ) hdmi_tx_raster_i (
    .hdmi_rx_clk   (hdmi_rx_clk),
    .reset_i       (reset_i),
    .mode_i        (pattern_mode_i),
    .solid_ycbcr_i (solid_ycbcr_i),
    .tx_data_o     (hdmi_tx_data_o)
  );

endmodule

`default_nettype wire

//--- verilog/video_delay.sv
// Fixed-depth register delay line for any payload type
`timescale 1ns/1ps
`default_nettype none

module video_delay #(
  parameter type T     = logic [video_pkg::VID_W-1:0],
  parameter int  DEPTH = 1
) (
  input  logic hdmi_rx_clk,
  input  logic reset_i,
  input  T     din_i,
  output T     dout_o
);

  // Stage 0 takes the input and the last stage drives the output
  T stages [DEPTH];

  always_ff @(posedge hdmi_rx_clk) begin
    if (reset_i) begin
      for (int i = 0; i < DEPTH; i++) begin
        stages[i] <= '0;
      end
    end else begin
      stages[0] <= din_i;
      // Each later stage copies its neighbour closer to the input
      for (int i = 1; i < DEPTH; i++) begin
        stages[i] <= stages[i-1];
      end
    end
  end

  assign dout_o = stages[DEPTH-1];

endmodule

`default_nettype wire

//--- verilog/video_pattern.sv
// Test pattern generator for colour bars, luma ramp and solid colour
`timescale 1ns/1ps
`default_nettype none

module video_pattern #(
  parameter int H_ACTIVE = 64
) (
  input  logic                        hdmi_rx_clk,
  input  logic                        reset_i,
  input  logic [1:0]                  mode_i,
  input  logic [23:0]                 solid_ycbcr_i,
  input  logic [video_pkg::CNT_W-1:0] pix_idx_i,
  input  logic                        first_pix_i,
  output logic [video_pkg::VID_W-1:0] pat_data_o
);

  typedef logic [video_pkg::CNT_W-1:0] cnt_t;

  // Width of one bar in pixels, never below one
  localparam int BAR_W = (H_ACTIVE / 8 > 0) ? H_ACTIVE / 8 : 1;

  logic [1:0] mode_q;
  logic [1:0] mode_sel;
  logic [23:0] solid_q;
  logic [23:0] solid_sel;
  cnt_t bar_div;
  logic [2:0] bar_idx;
  logic [7:0] luma;
  logic [7:0] cb;
  logic [7:0] cr;

  // The first pixel of a frame already uses the newly requested settings
  assign mode_sel = first_pix_i ? mode_i : mode_q;
  assign solid_sel = first_pix_i ? solid_ycbcr_i : solid_q;

  // Pixels past the eighth bar stay on the last one
  assign bar_div = pix_idx_i / cnt_t'(BAR_W);
  assign bar_idx = (bar_div > cnt_t'(7)) ? 3'd7 : bar_div[2:0];

  always_comb begin
    case (mode_sel)
      video_pkg::MODE_RAMP: begin
        // The ramp wraps every 256 pixels and has no colour
        luma = pix_idx_i[7:0];
        cb = 8'd128;
        cr = 8'd128;
      end
      video_pkg::MODE_SOLID: begin
        luma = solid_sel[23:16];
        cb = solid_sel[15:8];
        cr = solid_sel[7:0];
      end
      default: begin
        luma = video_pkg::BAR_Y[bar_idx];
        cb = video_pkg::BAR_CB[bar_idx];
        cr = video_pkg::BAR_CR[bar_idx];
      end
    endcase
  end

  // Settings are held for the whole frame
  always_ff @(posedge hdmi_rx_clk) begin
    if (reset_i) begin
      mode_q <= video_pkg::MODE_BARS;
      solid_q <= '0;
    end else if (first_pix_i) begin
      mode_q <= mode_i;
      solid_q <= solid_ycbcr_i;
    end
  end

  // Even pixels carry Cb and odd pixels carry Cr
  always_ff @(posedge hdmi_rx_clk) begin
    pat_data_o <= {luma, pix_idx_i[0] ? cr : cb};
  end

endmodule

`default_nettype wire

//--- verilog/video_pkg.sv
// Video word widths, embedded sync constants, colour-bar tables, XY coding and tx control type
`default_nettype none

package video_pkg;

  // ********************
  // Word and counter widths
  // ********************

  // One transceiver word carries luma in the upper byte and Cb or Cr in the lower byte
  localparam int VID_W = 16;
  // Pixel and line counters are wide enough for a full HD raster
  localparam int CNT_W = 12;

  // ********************
  // Embedded sync words
  // ********************

  // A sync code is SYNC_FF, SYNC_00, SYNC_00 and then the XY word
  localparam logic [VID_W-1:0] SYNC_FF = 16'hFFFF;
  localparam logic [VID_W-1:0] SYNC_00 = 16'h0000;
  // Blanking carries black luma and neutral chroma
  localparam logic [VID_W-1:0] BLANK_WORD = 16'h1080;

  // Colour bars from white down to black, in 8-bit limited range
  localparam logic [7:0] BAR_Y [8] = '{8'd235, 8'd210, 8'd170, 8'd145,
                                       8'd106, 8'd81, 8'd41, 8'd16};
  localparam logic [7:0] BAR_CB [8] = '{8'd128, 8'd16, 8'd166, 8'd54,
                                        8'd202, 8'd90, 8'd240, 8'd128};
  localparam logic [7:0] BAR_CR [8] = '{8'd128, 8'd146, 8'd16, 8'd34,
                                        8'd222, 8'd240, 8'd110, 8'd128};

  // Pattern modes; the unused code 3 falls back to bars
  localparam logic [1:0] MODE_BARS = 2'd0;
  localparam logic [1:0] MODE_RAMP = 2'd1;
  localparam logic [1:0] MODE_SOLID = 2'd2;

  // Builds the XY byte with its four protection bits from F, V and H
  function automatic logic [7:0] xy_code(input logic f, input logic v, input logic h);
    return {1'b1, f, v, h, v ^ h, f ^ h, f ^ v, f ^ v ^ h};
  endfunction

  // Per-slot control produced by the transmit raster counters
  typedef struct packed {
    logic             active;
    logic             code_en;
    logic [1:0]       code_idx;
    logic [7:0]       xy;
    logic [CNT_W-1:0] pix_idx;
    logic             first_pix;
  } tx_ctl_t;

endpackage

`default_nettype wire
